// File: logic/width_down_pkg.sv
`default_nettype none

package width_down_pkg;

  // Width of one input word as it arrives from the source
  localparam int WIDE_WIDTH = 64;

  // Width of one output beat as it leaves toward the sink
  localparam int NARROW_WIDTH = 16;

  // One wide input word
  typedef logic [WIDE_WIDTH-1:0] wide_word_t;

  // Data of one narrow output beat
  typedef logic [NARROW_WIDTH-1:0] narrow_slice_t;

  // Narrow slices carried by one wide word
  localparam int NUM_SLICES = $bits(wide_word_t) / $bits(narrow_slice_t);

  // Holds 0 up to NUM_SLICES inclusive
  // Zero means the serializer is empty
  typedef logic [$clog2(NUM_SLICES+1)-1:0] slice_count_t;

  // Word plus end-of-packet flag
  // Travels from ingress through the buffer to the serializer
  typedef struct packed {
    logic       last;
    wide_word_t data;
  } wide_beat_t;

  // Output beat
  // last marks the final slice of the final word of a packet
  typedef struct packed {
    logic          last;
    narrow_slice_t data;
  } narrow_beat_t;

endpackage

`default_nettype wire

// File: logic/word_ingress.sv
`timescale 1ns/1ps
`default_nettype none

module word_ingress
#(
  parameter int FIFO_DEPTH = 4
)
(
  input  wire                       CLK,
  input  wire                       RST_N,
  // Source side handshake
  input  wire                       in_vld,
  input  wire width_down_pkg::wide_beat_t in_beat,
  output logic                      in_rdy,
  // Registered push toward the buffer
  output logic                      push_vld,
  output width_down_pkg::wide_beat_t push_beat,
  // One pulse per freed buffer slot
  input  wire                       credit_ret
);

  // Counter must reach FIFO_DEPTH itself, not just FIFO_DEPTH-1
  typedef logic [$clog2(FIFO_DEPTH+1)-1:0] credit_t;

  credit_t credits_q;
  logic    accept;

  // Ready only while a free slot is guaranteed downstream
  assign in_rdy = (credits_q != '0);

  // Word taken from the source this cycle
  assign accept = in_vld & in_rdy;

  // Credit bookkeeping
  // Accept and return in the same cycle cancel out
  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      // Buffer starts empty so every slot is available
      credits_q <= credit_t'(FIFO_DEPTH);
    end
    else if (accept && !credit_ret)
    begin
      credits_q <= credits_q - credit_t'(1);
    end
    else if (!accept && credit_ret)
    begin
      credits_q <= credits_q + credit_t'(1);
    end
  end

  // Push strobe lasts one cycle per accepted word
  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      push_vld <= 1'b0;
    end
    else
    begin
      push_vld <= accept;
    end
  end

  // Payload only moves on an accept
  always_ff @(posedge CLK)
  begin
    if (accept)
    begin
      push_beat <= in_beat;
    end
  end

endmodule

`default_nettype wire

// File: logic/word_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module word_buffer
#(
  parameter int FIFO_DEPTH = 4
)
(
  input  wire                        CLK,
  input  wire                        RST_N,
  // Write side fed by the ingress block
  input  wire                        push_vld,
  input  wire width_down_pkg::wide_beat_t push_beat,
  // Returned one cycle after each pop
  output logic                       credit_ret,
  // Show-ahead read side
  output logic                       head_vld,
  output width_down_pkg::wide_beat_t head_beat,
  input  wire                        pop
);

  // Depth is a power of two so pointers wrap on their own
  typedef logic [$clog2(FIFO_DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(FIFO_DEPTH+1)-1:0] count_t;

  // Storage array
  width_down_pkg::wide_beat_t mem [FIFO_DEPTH];

  ptr_t   wr_ptr_q;
  ptr_t   rd_ptr_q;
  count_t count_q;

  // Oldest entry is always presented
  assign head_vld  = (count_q != '0);
  assign head_beat = mem[rd_ptr_q];

  // Write into the array
  // No full check here since a push implies a credit was held
  always_ff @(posedge CLK)
  begin
    if (push_vld)
    begin
      mem[wr_ptr_q] <= push_beat;
    end
  end

  // Pointer movement
  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else
    begin
      if (push_vld)
      begin
        wr_ptr_q <= wr_ptr_q + ptr_t'(1);
      end
      if (pop)
      begin
        rd_ptr_q <= rd_ptr_q + ptr_t'(1);
      end
    end
  end

  // Occupancy
  // Push and pop together leave it unchanged
  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      count_q <= '0;
    end
    else if (push_vld && !pop)
    begin
      count_q <= count_q + count_t'(1);
    end
    else if (!push_vld && pop)
    begin
      count_q <= count_q - count_t'(1);
    end
  end

  // Each freed slot goes back as a one-cycle credit
  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      credit_ret <= 1'b0;
    end
    else
    begin
      credit_ret <= pop;
    end
  end

endmodule

`default_nettype wire

// File: logic/beat_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module beat_serializer
(
  input  wire                          CLK,
  input  wire                          RST_N,
  // Show-ahead head of the buffer
  input  wire                          head_vld,
  input  wire width_down_pkg::wide_beat_t head_beat,
  output logic                         pop,
  // Narrow output handshake
  output logic                         out_vld,
  output width_down_pkg::narrow_beat_t out_beat,
  input  wire                          out_rdy
);

  // Slice width taken from the package type
  localparam int SLICE_W = $bits(width_down_pkg::narrow_slice_t);

  // Word being shifted out
  // Low slice is always the one on the output
  width_down_pkg::wide_word_t shift_q;

  // Slices still to send, zero when idle
  width_down_pkg::slice_count_t remain_q;

  // Packet end flag of the loaded word
  logic last_q;

  logic beat_done;
  logic final_done;

  // Busy as long as slices remain
  assign out_vld = (remain_q != '0);

  // Beat accepted by the sink
  assign beat_done = out_vld & out_rdy;

  // The accepted beat was the last slice of the word
  assign final_done = beat_done & (remain_q == width_down_pkg::slice_count_t'(1));

  // Pull a new word when idle or when the current one just finished
  // Reloading on the final beat avoids a bubble between words
  assign pop = head_vld & (~out_vld | final_done);

  // Output beat comes straight from the register
  assign out_beat.data = shift_q[SLICE_W-1:0];
  // Last only on the final slice of a flagged word
  assign out_beat.last = last_q & (remain_q == width_down_pkg::slice_count_t'(1));

  // Slice counter and stored flag
  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      remain_q <= '0;
      last_q   <= 1'b0;
    end
    else if (pop)
    begin
      // Full word loaded
      remain_q <= width_down_pkg::slice_count_t'(width_down_pkg::NUM_SLICES);
      last_q   <= head_beat.last;
    end
    else if (beat_done)
    begin
      remain_q <= remain_q - width_down_pkg::slice_count_t'(1);
    end
  end

  // Parallel load and right shift
  always_ff @(posedge CLK)
  begin
    if (pop)
    begin
      shift_q <= head_beat.data;
    end
    else if (beat_done)
    begin
      // Next higher slice drops into the low position
      shift_q <= shift_q >> SLICE_W;
    end
  end

endmodule

`default_nettype wire

// File: logic/width_down_top.sv
`timescale 1ns/1ps
`default_nettype none

module width_down_top
#(
  // Buffer depth and initial credit count
  parameter int FIFO_DEPTH = 4
)
(
  input  wire                          CLK,
  input  wire                          RST_N,
  // Wide input side
  input  wire                          in_vld,
  input  wire width_down_pkg::wide_beat_t in_beat,
  output logic                         in_rdy,
  // Narrow output side
  output logic                         out_vld,
  output width_down_pkg::narrow_beat_t out_beat,
  input  wire                          out_rdy
);

  // Ingress to buffer
  logic                       push_vld;
  width_down_pkg::wide_beat_t push_beat;
  logic                       credit_ret;

  // Buffer to serializer
  logic                       head_vld;
  width_down_pkg::wide_beat_t head_beat;
  logic                       pop;

  // Accepts words while credits remain
  word_ingress #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) ingress_i (
    .CLK        (CLK),
    .RST_N      (RST_N),
    .in_vld     (in_vld),
    .in_beat    (in_beat),
    .in_rdy     (in_rdy),
    .push_vld   (push_vld),
    .push_beat  (push_beat),
    .credit_ret (credit_ret)
  );

  // Storage between the two sides
  word_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) buffer_i (
    .CLK        (CLK),
    .RST_N      (RST_N),
    .push_vld   (push_vld),
    .push_beat  (push_beat),
    .credit_ret (credit_ret),
    .head_vld   (head_vld),
    .head_beat  (head_beat),
    .pop        (pop)
  );

  // Splits each word into narrow beats
  beat_serializer serializer_i (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .head_vld  (head_vld),
    .head_beat (head_beat),
    .pop       (pop),
    .out_vld   (out_vld),
    .out_beat  (out_beat),
    .out_rdy   (out_rdy)
  );

endmodule

`default_nettype wire

// File: tests/tb_width_down.sv
`timescale 1ns/1ps
`default_nettype none

module tb_width_down;

  localparam int FIFO_DEPTH = 4;
  // Output slice width and slices per word
  localparam int SLICE_W = 16;
  localparam int NUM_SLICES = 64 / SLICE_W;
  // Cycle limits for the wait loops
  localparam int SEND_TIMEOUT = 200;
  localparam int DRAIN_TIMEOUT = 2000;
  localparam int RANDOM_LIMIT = 20000;
  localparam int RANDOM_WORDS = 200;

  logic                         CLK;
  logic                         RST_N;
  logic                         in_vld;
  width_down_pkg::wide_beat_t   in_beat;
  logic                         in_rdy;
  logic                         out_vld;
  width_down_pkg::narrow_beat_t out_beat;
  logic                         out_rdy;

  // Beats still owed by the DUT, oldest first
  width_down_pkg::narrow_beat_t exp_q[$];

  logic [31:0] lfsr_q;
  string       cur_test;
  int          errors;
  int          errors_at_start;
  int          beats_checked;
  int          beats_at_start;
  int          tests_run;
  int          tests_passed;

  width_down_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) dut_i (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .in_vld   (in_vld),
    .in_beat  (in_beat),
    .in_rdy   (in_rdy),
    .out_vld  (out_vld),
    .out_beat (out_beat),
    .out_rdy  (out_rdy)
  );

  // 40 ns clock
  initial
  begin
    CLK = 1'b0;
    forever
    begin
      #20 CLK = ~CLK;
    end
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One LFSR step per bit
  // Newest bit lands at the bottom
  task automatic next_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[62:0], lfsr_q[0]};
    end
  endtask

  // Slice idx of a word
  // Last only on the top slice of a flagged word
  function automatic width_down_pkg::narrow_beat_t expected_slice(
    input width_down_pkg::wide_beat_t w,
    input int idx
  );
    width_down_pkg::narrow_beat_t b;
    b.data = w.data[idx*SLICE_W +: SLICE_W];
    b.last = w.last && (idx == NUM_SLICES - 1);
    return b;
  endfunction

  // Compare process sampled at the rising edge
  always @(posedge CLK)
  begin : compare_proc
    width_down_pkg::narrow_beat_t want;
    if (RST_N)
    begin
      if (out_vld && out_rdy)
      begin
        // Every beat the sink takes is counted
        beats_checked++;
        if (exp_q.size() == 0)
        begin
          $display("ERROR %s: output beat %h arrived with nothing expected", cur_test, out_beat);
          errors++;
        end
        else
        begin
          want = exp_q.pop_front();
          assert (out_beat === want)
          else
          begin
            $display("FAIL %s expected %h actual %h", cur_test, want, out_beat);
            errors++;
          end
        end
      end
      // Every accepted word owes NUM_SLICES beats
      if (in_vld && in_rdy)
      begin
        for (int i = 0; i < NUM_SLICES; i++)
        begin
          exp_q.push_back(expected_slice(in_beat, i));
        end
      end
    end
  end

  task automatic open_test(input string name);
    cur_test = name;
    errors_at_start = errors;
    beats_at_start = beats_checked;
  endtask

  task automatic close_test();
    tests_run++;
    if (errors == errors_at_start)
    begin
      tests_passed++;
      $display("test %s passed", cur_test);
    end
    else
    begin
      $display("test %s failed with %0d errors", cur_test, errors - errors_at_start);
    end
  endtask

  // Entered and left just after a falling edge
  // in_vld stays as it was left
  task automatic send_word(input width_down_pkg::wide_beat_t w);
    int   waited;
    logic taken;
    waited = 0;
    taken = 1'b0;
    in_vld = 1'b1;
    in_beat = w;
    while (!taken && waited < SEND_TIMEOUT)
    begin
      @(posedge CLK);
      taken = in_rdy;
      waited++;
    end
    @(negedge CLK);
    if (!taken)
    begin
      $display("ERROR %s: in_rdy stayed low for %0d cycles", cur_test, SEND_TIMEOUT);
      errors++;
      in_vld = 1'b0;
    end
  endtask

  // Until every expected beat has come out
  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((exp_q.size() != 0 || out_vld) && waited < DRAIN_TIMEOUT)
    begin
      @(negedge CLK);
      waited++;
    end
    if (exp_q.size() != 0 || out_vld)
    begin
      $display("ERROR %s: output did not drain, %0d beats still missing", cur_test,
               exp_q.size());
      errors++;
    end
    // Idle a little so a stray extra beat is caught
    repeat (4) @(negedge CLK);
  endtask

  task automatic check_beat_count(input int expected);
    int actual;
    actual = beats_checked - beats_at_start;
    assert (actual == expected)
    else
    begin
      $display("FAIL %s expected %0d actual %0d", cur_test, expected, actual);
      errors++;
    end
  endtask

  task automatic single_word();
    width_down_pkg::wide_beat_t w;
    open_test("single_word");
    out_rdy = 1'b1;
    w.data = 64'h4444_3333_2222_1111;
    w.last = 1'b1;
    send_word(w);
    in_vld = 1'b0;
    wait_drain();
    check_beat_count(NUM_SLICES);
    close_test();
  endtask

  task automatic multi_word_packets();
    width_down_pkg::wide_beat_t w;
    logic [63:0]                bits;
    int                         total;
    open_test("multi_word_packets");
    out_rdy = 1'b1;
    total = 0;
    // Packet lengths 1 to 5 sent back to back
    for (int n = 1; n <= 5; n++)
    begin
      for (int k = 0; k < n; k++)
      begin
        next_bits(64, bits);
        w.data = bits;
        w.last = (k == n - 1);
        send_word(w);
        total++;
      end
    end
    in_vld = 1'b0;
    wait_drain();
    check_beat_count(total * NUM_SLICES);
    close_test();
  endtask

  task automatic random_traffic();
    width_down_pkg::wide_beat_t w;
    logic [63:0]                bits;
    int                         sent;
    int                         cycles;
    logic                       taken;
    open_test("random_traffic");
    sent = 0;
    cycles = 0;
    while (sent < RANDOM_WORDS && cycles < RANDOM_LIMIT)
    begin
      // Random gap before a new word
      if (!in_vld)
      begin
        next_bits(1, bits);
        if (bits[0])
        begin
          next_bits(64, bits);
          w.data = bits;
          next_bits(1, bits);
          w.last = bits[0];
          in_beat = w;
          in_vld = 1'b1;
        end
      end
      // Sink stalls about a quarter of the time
      next_bits(2, bits);
      out_rdy = (bits[1:0] != 2'b00);
      @(posedge CLK);
      taken = in_vld && in_rdy;
      @(negedge CLK);
      if (taken)
      begin
        sent++;
        in_vld = 1'b0;
      end
      cycles++;
    end
    if (sent < RANDOM_WORDS)
    begin
      $display("ERROR %s: only %0d words accepted in %0d cycles", cur_test, sent, RANDOM_LIMIT);
      errors++;
    end
    in_vld = 1'b0;
    out_rdy = 1'b1;
    wait_drain();
    check_beat_count(sent * NUM_SLICES);
    close_test();
  endtask

  task automatic fill_to_credit_limit();
    width_down_pkg::wide_beat_t w;
    logic [63:0]                bits;
    int                         accepted;
    logic                       rdy_seen;
    open_test("fill_to_credit_limit");
    out_rdy = 1'b0;
    accepted = 0;
    rdy_seen = 1'b0;
    next_bits(64, bits);
    w.data = bits;
    w.last = 1'b0;
    in_beat = w;
    in_vld = 1'b1;
    // in_vld held high makes every in_rdy at an edge an accept
    for (int c = 0; c < 30; c++)
    begin
      @(posedge CLK);
      if (in_rdy)
      begin
        accepted++;
        @(negedge CLK);
        next_bits(64, bits);
        w.data = bits;
        w.last = (accepted == FIFO_DEPTH);
        in_beat = w;
      end
      else
      begin
        @(negedge CLK);
      end
    end
    assert (accepted == FIFO_DEPTH + 1)
    else
    begin
      $display("FAIL %s expected %0d actual %0d", cur_test, FIFO_DEPTH + 1, accepted);
      errors++;
    end
    // Credits are gone so ready must stay low
    for (int c = 0; c < 20; c++)
    begin
      @(posedge CLK);
      rdy_seen = rdy_seen | in_rdy;
      @(negedge CLK);
    end
    assert (!rdy_seen)
    else
    begin
      $display("ERROR %s: in_rdy rose while the sink was stalled", cur_test);
      errors++;
    end
    // Releasing the sink lets the pending word in
    out_rdy = 1'b1;
    send_word(w);
    in_vld = 1'b0;
    wait_drain();
    check_beat_count((accepted + 1) * NUM_SLICES);
    close_test();
  endtask

  task automatic reset_mid_stream();
    width_down_pkg::wide_beat_t w;
    logic [63:0]                bits;
    open_test("reset_mid_stream");
    // Stalled sink lets the cut packet use up every credit
    out_rdy = 1'b0;
    for (int k = 0; k <= FIFO_DEPTH; k++)
    begin
      next_bits(64, bits);
      w.data = bits;
      w.last = 1'b0;
      send_word(w);
    end
    in_vld = 1'b0;
    repeat (2) @(negedge CLK);
    // Packet on the output and no credit left
    @(posedge CLK);
    assert ({out_vld, in_rdy} === 2'b10)
    else
    begin
      $display("FAIL %s expected %b actual %b", cur_test, 2'b10, {out_vld, in_rdy});
      errors++;
    end
    @(negedge CLK);
    RST_N = 1'b0;
    @(posedge CLK);
    assert ({out_vld, in_rdy} === 2'b01)
    else
    begin
      $display("FAIL %s expected %b actual %b", cur_test, 2'b01, {out_vld, in_rdy});
      errors++;
    end
    repeat (3) @(negedge CLK);
    // Beats of the cut packet are gone for good
    exp_q.delete();
    out_rdy = 1'b1;
    RST_N = 1'b1;
    beats_at_start = beats_checked;
    for (int k = 0; k < 2; k++)
    begin
      next_bits(64, bits);
      w.data = bits;
      w.last = (k == 1);
      send_word(w);
    end
    in_vld = 1'b0;
    wait_drain();
    check_beat_count(2 * NUM_SLICES);
    close_test();
  endtask

  initial
  begin
    RST_N = 1'b0;
    in_vld = 1'b0;
    in_beat = '0;
    out_rdy = 1'b0;
    lfsr_q = 32'd80230;
    cur_test = "reset";
    errors = 0;
    errors_at_start = 0;
    beats_checked = 0;
    beats_at_start = 0;
    tests_run = 0;
    tests_passed = 0;
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    RST_N = 1'b1;
    @(negedge CLK);
    single_word();
    multi_word_packets();
    random_traffic();
    fill_to_credit_limit();
    reset_mid_stream();
    $display("%0d tests, %0d passed, %0d failed, %0d beats checked, %0d errors",
             tests_run, tests_passed, tests_run - tests_passed, beats_checked, errors);
    if (errors == 0 && tests_passed == tests_run)
    begin
      $display("Test completed successfully");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
logic/width_down_pkg.sv
logic/word_ingress.sv
logic/word_buffer.sv
logic/beat_serializer.sv
logic/width_down_top.sv
tests/tb_width_down.sv

// File: run.sh
#!/bin/sh
# Build and run the width down-converter testbench with Verilator
set -e

# Work from the project root so flist.f paths resolve
cd "$(dirname "$0")"

LOG=sim.log
TOP=tb_width_down

# Fresh build each run
rm -rf obj_dir

# --assert enables the immediate assertions in the testbench
verilator --binary --timing --assert \
  -f flist.f \
  --top-module "$TOP"

# Run the simulation and keep its output
./obj_dir/V"$TOP" > "$LOG" 2>&1
cat "$LOG"

# The testbench prints its fail line on any error or timeout
if grep -q "Test failed" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
